//--- src/cordic_params.svh
`ifndef CORDIC_PARAMS_SVH
`define CORDIC_PARAMS_SVH

// fixed-point word, Q2.30
`define CORDIC_WIDTH     32
`define CORDIC_FRAC_BITS 30

// rotation steps, one per atan table entry
`define CORDIC_STEPS     16

// 1/K for the rotation gain, loaded into x at start
`define CORDIC_GAIN_SEED 32'sh26DD_3B6A

// exact special results
`define COS_ONE_WORD     32'h3F80_0000
`define COS_NAN_WORD     32'h7FC0_0000

`endif

//--- src/fp_pkg.sv
`default_nettype none

package fp_pkg;

    // ieee-754 single precision layout
    typedef struct packed {
        logic       sign;
        logic [7:0] exponent;
        logic [22:0] mantissa;
    } fp32_fields_t;

    // same word, seen raw or split into fields
    typedef union packed {
        logic [31:0]  raw;
        fp32_fields_t fields;
    } fp32_t;

    // class of the operand, latched at start
    typedef enum logic [1:0] {
        op_normal       = 2'd0,
        op_zero         = 2'd1,
        op_out_of_range = 2'd2
    } operand_class_t;

endpackage

`default_nettype wire

//--- src/cordic_pkg.sv
`default_nettype none

`include "cordic_params.svh"

package cordic_pkg;

    // ------------------------------------------------------------------
    // rotation state
    // ------------------------------------------------------------------
    // x, y, z all in Q2.30
    // x ends as cos, y as sin, z is the residual angle
    typedef struct packed {
        logic signed [`CORDIC_WIDTH-1:0] x;
        logic signed [`CORDIC_WIDTH-1:0] y;
        logic signed [`CORDIC_WIDTH-1:0] z;
    } cordic_state_t;

    // ------------------------------------------------------------------
    // step counter
    // ------------------------------------------------------------------
    // counts 0 to CORDIC_STEPS, the top value means finished
    typedef logic [$clog2(`CORDIC_STEPS + 1)-1:0] step_index_t;

endpackage

`default_nettype wire

//--- src/cordic_rotator.sv
`timescale 1ns/10ps
`default_nettype none

`include "cordic_params.svh"

module cordic_rotator (
    input  wire logic                     clock,
    input  wire logic                     rst,
    input  wire logic                     clk_en,
    input  wire logic                     start,
    input  wire fp_pkg::fp32_t            operand,
    output cordic_pkg::cordic_state_t     state,
    output logic                          done
);
    import cordic_pkg::*;

    step_index_t                     step;
    logic                            has_run;
    logic                            finished;
    logic [`CORDIC_WIDTH-1:0]        aligned;
    logic [7:0]                      shift;
    cordic_state_t                   load_state;
    cordic_state_t                   next_state;
    logic signed [`CORDIC_WIDTH-1:0] angle;
    logic signed [`CORDIC_WIDTH-1:0] x_shr;
    logic signed [`CORDIC_WIDTH-1:0] y_shr;

    // ------------------------------------------------------------------
    // float to Q2.30
    // ------------------------------------------------------------------
    // hidden one lands on bit 30
    // sign dropped since cos is even
    assign aligned = {2'b01, operand.fields.mantissa, {(`CORDIC_WIDTH - 25){1'b0}}};
    // exponent 0 shifts everything out
    assign shift   = 8'd127 - operand.fields.exponent;

    always_comb begin
        load_state.x = `CORDIC_GAIN_SEED;
        load_state.y = '0;
        load_state.z = aligned >> shift;
    end

    // ------------------------------------------------------------------
    // atan(2^-i) in Q2.30
    // ------------------------------------------------------------------
    always_comb begin
        case (step[3:0])
            4'd0:    angle = 32'sh3243_F6A8;
            4'd1:    angle = 32'sh1DAC_6705;
            4'd2:    angle = 32'sh0FAD_BAFC;
            4'd3:    angle = 32'sh07F5_6EA6;
            4'd4:    angle = 32'sh03FE_AB76;
            4'd5:    angle = 32'sh01FF_D55B;
            4'd6:    angle = 32'sh00FF_FAAA;
            4'd7:    angle = 32'sh007F_FF55;
            4'd8:    angle = 32'sh003F_FFEA;
            4'd9:    angle = 32'sh001F_FFFD;
            4'd10:   angle = 32'sh0010_0000;
            4'd11:   angle = 32'sh0008_0000;
            4'd12:   angle = 32'sh0004_0000;
            4'd13:   angle = 32'sh0002_0000;
            4'd14:   angle = 32'sh0001_0000;
            default: angle = 32'sh0000_8000;
        endcase
    end

    // one rotation toward z = 0
    always_comb begin
        x_shr = state.x >>> step;
        y_shr = state.y >>> step;
        if (!state.z[`CORDIC_WIDTH-1]) begin
            next_state.x = state.x - y_shr;
            next_state.y = state.y + x_shr;
            next_state.z = state.z - angle;
        end else begin
            next_state.x = state.x + y_shr;
            next_state.y = state.y - x_shr;
            next_state.z = state.z + angle;
        end
    end

    // ------------------------------------------------------------------
    // step control
    // ------------------------------------------------------------------
    assign finished = (step == step_index_t'(`CORDIC_STEPS));
    assign done     = has_run && finished;

    always_ff @(posedge clock) begin
        if (rst) begin
            step    <= step_index_t'(`CORDIC_STEPS);
            has_run <= 1'b0;
        end else if (clk_en) begin
            if (start) begin
                step    <= '0;
                has_run <= 1'b1;
            end else if (!finished) begin
                step <= step + step_index_t'(1);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (clk_en) begin
            if (start) begin
                state <= load_state;
            end else if (!finished) begin
                state <= next_state;
            end
        end
    end

    step_in_range: assert property (@(posedge clock) disable iff (rst)
        step <= step_index_t'(`CORDIC_STEPS));

    // a restart always drops done on the next edge
    done_drops_on_start: assert property (@(posedge clock) disable iff (rst)
        (clk_en && start) |=> !done);

endmodule

`default_nettype wire

//--- src/cos_operand_classifier.sv
`timescale 1ns/10ps
`default_nettype none

module cos_operand_classifier (
    input  wire logic              clock,
    input  wire logic              rst,
    input  wire logic              clk_en,
    input  wire logic              start,
    input  wire fp_pkg::fp32_t     operand,
    output fp_pkg::operand_class_t op_class
);
    import fp_pkg::*;

    operand_class_t next_class;

    // zero and denormal both collapse to cos = 1
    // anything at or above 2.0, inf and nan included, is out of range
    always_comb begin
        if (operand.fields.exponent == 8'd0) begin
            next_class = op_zero;
        end else if (operand.fields.exponent > 8'd127) begin
            next_class = op_out_of_range;
        end else begin
            next_class = op_normal;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            op_class <= op_normal;
        end else if (clk_en && start) begin
            op_class <= next_class;
        end
    end

    class_encoding_valid: assert property (@(posedge clock) disable iff (rst)
        op_class inside {op_normal, op_zero, op_out_of_range});

endmodule

`default_nettype wire

//--- src/cos_result_packer.sv
`timescale 1ns/10ps
`default_nettype none

`include "cordic_params.svh"

module cos_result_packer (
    input  wire logic signed [`CORDIC_WIDTH-1:0] x,
    input  wire fp_pkg::operand_class_t          op_class,
    input  wire logic                            done,
    output fp_pkg::fp32_t                        result
);
    import fp_pkg::*;

    logic [4:0]               lead_pos;
    logic                     found;
    logic [`CORDIC_WIDTH-1:0] norm;
    fp32_t                    packed_word;

    // ------------------------------------------------------------------
    // leading one, searched below the sign bit
    // ------------------------------------------------------------------
    always_comb begin
        lead_pos = '0;
        found    = 1'b0;
        for (int i = 0; i < `CORDIC_WIDTH - 1; i++) begin
            if (x[i]) begin
                lead_pos = 5'(i);
                found    = 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------
    // normalize to float
    // ------------------------------------------------------------------
    // move the leading one up to bit 30, the Q2.30 unit position
    assign norm = x << (5'(`CORDIC_FRAC_BITS) - lead_pos);

    always_comb begin
        packed_word.fields.sign     = 1'b0;
        packed_word.fields.exponent = 8'(127 - `CORDIC_FRAC_BITS) + 8'(lead_pos);
        packed_word.fields.mantissa = norm[`CORDIC_FRAC_BITS-1 -: 23];
    end

    // special classes win over the rotator output
    always_comb begin
        case (op_class)
            op_zero:         result.raw = `COS_ONE_WORD;
            op_out_of_range: result.raw = `COS_NAN_WORD;
            default:         result.raw = found ? packed_word.raw : 32'h0000_0000;
        endcase
    end

    // a normal operand gives |cos| <= 1, so never an exponent past 127
    always_comb begin
        if (done && op_class == op_normal) begin
            normal_exponent_bound: assert (result.fields.exponent <= 8'd127);
        end
    end

endmodule

`default_nettype wire

//--- src/cordic_cos.sv
`timescale 1ns/10ps
`default_nettype none

module cordic_cos (
    input  wire logic          clock,
    input  wire logic          rst,
    input  wire logic          clk_en,
    input  wire logic          start,
    input  wire fp_pkg::fp32_t operand,
    output fp_pkg::fp32_t      result,
    output logic               done
);
    import fp_pkg::*;
    import cordic_pkg::*;

    cordic_state_t  state;
    operand_class_t op_class;

    // ------------------------------------------------------------------
    // rotator and classifier start together
    // ------------------------------------------------------------------
    cordic_rotator u_rotator (
        .clock   (clock),
        .rst     (rst),
        .clk_en  (clk_en),
        .start   (start),
        .operand (operand),
        .state   (state),
        .done    (done)
    );

    cos_operand_classifier u_classifier (
        .clock    (clock),
        .rst      (rst),
        .clk_en   (clk_en),
        .start    (start),
        .operand  (operand),
        .op_class (op_class)
    );

    // only the final x matters for cos
    cos_result_packer u_packer (
        .x        (state.x),
        .op_class (op_class),
        .done     (done),
        .result   (result)
    );

endmodule

`default_nettype wire

//--- testbench/cos_checker.sv
`timescale 1ns/10ps
`default_nettype none

module cos_checker (
    input  wire logic          clock,
    input  wire logic          rst,
    input  wire logic          clk_en,
    input  wire logic          start,
    input  wire logic          done,
    input  wire fp_pkg::fp32_t result,
    input  wire logic          check,
    input  wire logic          missed,
    input  wire logic [31:0]   test_index,
    input  wire logic [31:0]   operand_word,
    input  wire logic [31:0]   expected_word,
    input  wire logic [31:0]   tolerance,
    output int                 pass_count,
    output int                 fail_count
);
    import fp_pkg::*;

    logic        started;
    logic        busy;
    logic        held;
    int          edge_count;
    logic [31:0] held_word;
    logic [31:0] prev_operand;
    logic [31:0] prev_result;
    logic [31:0] distance;
    logic        ok;

    // positive floats order like their raw words
    function automatic logic [31:0] ulp_distance(input logic [31:0] a, input logic [31:0] b);
        return (a > b) ? (a - b) : (b - a);
    endfunction

    always @(posedge clock) begin
        if (rst) begin
            started      = 1'b0;
            busy         = 1'b0;
            held         = 1'b0;
            edge_count   = 0;
            pass_count   = 0;
            fail_count   = 0;
            prev_operand = '1;
            prev_result  = '0;
        end else begin
            if (!started && done) begin
                $display("done is high at %0t although no start was issued yet", $time);
                fail_count++;
            end
            // ----------------------------------------------------------------------
            // latency, counted in enabled edges
            // ----------------------------------------------------------------------
            if (clk_en && start) begin
                started    = 1'b1;
                busy       = 1'b1;
                held       = 1'b0;
                edge_count = 0;
            end else if (busy && clk_en && !done) begin
                edge_count++;
            end
            // result must hold until the next start
            if (held && (!done || result.raw != held_word)) begin
                $display("[ERROR] t=%0t result: got %h expected %h (done=%0b, not held)",
                         $time, result.raw, held_word, done);
                fail_count++;
                held = 1'b0;
            end
            if (missed) begin
                $display("test %0d: FAIL, done never arrived after start", test_index);
                fail_count++;
                busy = 1'b0;
            end
            if (check) begin
                ok       = 1'b1;
                distance = ulp_distance(result.raw, expected_word);
                if (distance > tolerance) begin
                    $display("[ERROR] t=%0t result: got %h expected %h (exp %0d man %h, %0d ulps)",
                             $time, result.raw, expected_word, result.fields.exponent,
                             result.fields.mantissa, distance);
                    ok = 1'b0;
                end
                if (edge_count != `CORDIC_STEPS) begin
                    $display("test %0d: done came after %0d enabled edges instead of 16",
                             test_index, edge_count);
                    ok = 1'b0;
                end
                // negative twin follows its positive operand
                if (operand_word == (prev_operand ^ 32'h8000_0000) &&
                    result.raw != prev_result) begin
                    $display("[ERROR] t=%0t result: got %h expected %h (sign twin)",
                             $time, result.raw, prev_result);
                    ok = 1'b0;
                end
                prev_operand = operand_word;
                prev_result  = result.raw;
                held         = 1'b1;
                held_word    = result.raw;
                busy         = 1'b0;
                if (ok) begin
                    pass_count++;
                    $display("test %0d: pass, operand %h result %h", test_index,
                             operand_word, result.raw);
                end else begin
                    fail_count++;
                    $display("test %0d: FAIL, operand %h", test_index, operand_word);
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/tb_cordic_cos.sv
`timescale 1ns/10ps
`default_nettype none

`include "cordic_params.svh"

module tb_cordic_cos;
    import fp_pkg::*;

    localparam int NUM_TESTS       = 18;
    localparam int RESET_CYCLES    = 5;
    localparam int MAX_GAP         = 3;
    localparam int DONE_WAIT_EDGES = `CORDIC_STEPS + 4;
    localparam int CYCLE_LIMIT     = (NUM_TESTS * (17 + MAX_GAP * 16) + RESET_CYCLES) * 2;

    logic        clock = 1'b0;
    logic        rst;
    logic        clk_en;
    logic        start;
    fp32_t       operand;
    fp32_t       result;
    logic        done;
    logic        check;
    logic        missed;
    logic [31:0] test_index;
    logic [31:0] operand_word;
    logic [31:0] expected_word;
    logic [31:0] tolerance;
    int          pass_count;
    int          fail_count;
    int          cycle_count = 0;
    logic [95:0] trace_mem [0:NUM_TESTS-1];

    always #2 clock = ~clock;

    cordic_cos u_dut (
        .clock   (clock),
        .rst     (rst),
        .clk_en  (clk_en),
        .start   (start),
        .operand (operand),
        .result  (result),
        .done    (done)
    );

    cos_checker u_checker (
        .clock         (clock),
        .rst           (rst),
        .clk_en        (clk_en),
        .start         (start),
        .done          (done),
        .result        (result),
        .check         (check),
        .missed        (missed),
        .test_index    (test_index),
        .operand_word  (operand_word),
        .expected_word (expected_word),
        .tolerance     (tolerance),
        .pass_count    (pass_count),
        .fail_count    (fail_count)
    );

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failures found");
            $finish;
        end
    end

    // ----------------------------------------------------------------------
    // stimulus, all driven on the falling edge
    // ----------------------------------------------------------------------
    task automatic enabled_edge(input logic use_gaps);
        int gap;
        begin
            if (use_gaps) begin
                gap = $urandom % (MAX_GAP + 1);
                repeat (gap) begin
                    clk_en = 1'b0;
                    @(negedge clock);
                end
            end
            clk_en = 1'b1;
            @(negedge clock);
        end
    endtask

    task automatic issue_start(input logic [31:0] word);
        operand.raw = word;
        start       = 1'b1;
        clk_en      = 1'b1;
        @(negedge clock);
        start = 1'b0;
    endtask

    task automatic run_test(input int idx);
        logic use_gaps;
        logic restart;
        int   waited;
        begin
            {operand_word, expected_word, tolerance} = trace_mem[idx];
            test_index = idx;
            use_gaps   = (idx % 3 == 1);
            restart    = (idx % 3 == 2);
            // abandoned operation first
            if (restart) begin
                issue_start(32'h3E99_999A);
                repeat (5) enabled_edge(1'b0);
            end
            issue_start(operand_word);
            waited = 0;
            while (!done && waited < DONE_WAIT_EDGES) begin
                enabled_edge(use_gaps);
                waited++;
            end
            if (done) begin
                check = 1'b1;
                @(negedge clock);
                check = 1'b0;
            end else begin
                missed = 1'b1;
                @(negedge clock);
                missed = 1'b0;
            end
            repeat (4) enabled_edge(use_gaps);
        end
    endtask

    initial begin
        void'($urandom(81805));
        rst           = 1'b1;
        clk_en        = 1'b0;
        start         = 1'b0;
        operand.raw   = '0;
        check         = 1'b0;
        missed        = 1'b0;
        test_index    = '0;
        operand_word  = '0;
        expected_word = '0;
        tolerance     = '0;
        $readmemh("testbench/cos_trace.hex", trace_mem);
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        rst    = 1'b0;
        clk_en = 1'b1;
        // idle period, done must stay low
        repeat (3) @(negedge clock);
        for (int i = 0; i < NUM_TESTS; i++) begin
            run_test(i);
        end
        @(negedge clock);
        $display("summary: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/cos_trace.hex
// columns: operand word _ expected result word _ tolerance in ulps
// one 96-bit entry per test, read with $readmemh
0000_0000_3F80_0000_0000_0000
8000_0000_3F80_0000_0000_0000
0000_0001_3F80_0000_0000_0000
007F_FFFF_3F80_0000_0000_0000
3E00_0000_3F7E_00AA_0000_0800
3E80_0000_3F78_0AA5_0000_0800
3F00_0000_3F60_A940_0000_0800
BF00_0000_3F60_A940_0000_0800
3F40_0000_3F3B_4FF6_0000_0800
3F80_0000_3F0A_5140_0000_0800
BF80_0000_3F0A_5140_0000_0800
3FA0_0000_3EA1_71EF_0000_2000
3FC0_0000_3D90_DEAB_0000_8000
BFC0_0000_3D90_DEAB_0000_8000
4000_0000_7FC0_0000_0000_0000
7F80_0000_7FC0_0000_0000_0000
C040_0000_7FC0_0000_0000_0000
7FC0_0000_7FC0_0000_0000_0000

//--- compile.f
+incdir+src
src/fp_pkg.sv
src/cordic_pkg.sv
src/cordic_rotator.sv
src/cos_operand_classifier.sv
src/cos_result_packer.sv
src/cordic_cos.sv
testbench/cos_checker.sv
testbench/tb_cordic_cos.sv

//--- Makefile
VERILATOR  = verilator
FLAGS      = --timing --assert
TOP        = tb_cordic_cos
RTL_TOP    = cordic_cos
FILE_LIST  = compile.f
OBJ_DIR    = obj_dir
PASS_TEXT  = All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILE_LIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(shell grep -v '^+' $(FILE_LIST)) $(FILE_LIST)
	$(VERILATOR) --binary $(FLAGS) -f $(FILE_LIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
